//--- design/mem_island_cfg_pkg.sv
/*
 * Memory island configuration: bank geometry, port counts and the
 * positions of the bank and row fields inside a byte address.
 */
package mem_island_cfg_pkg;

  // Port counts and data widths
  localparam int unsigned NumNarrowPorts  = 2;
  localparam int unsigned NarrowWidth     = 32;
  localparam int unsigned WideWidth       = 64;
  localparam int unsigned NarrowStrbWidth = NarrowWidth / 8;
  localparam int unsigned WideStrbWidth   = WideWidth / 8;

  // Banking
  localparam int unsigned PartsPerWide = WideWidth / NarrowWidth;
  localparam int unsigned NumWideBanks = 2;
  localparam int unsigned NumBanks     = PartsPerWide * NumWideBanks;
  localparam int unsigned WordsPerBank = 64;

  // Address map: row | wide bank | narrow bank | byte offset
  localparam int unsigned AddrWidth     = 16;
  localparam int unsigned NarrowBankBit = 2;
  localparam int unsigned WideBankBit   = 3;
  localparam int unsigned RowLsb        = 4;

  // Derived field widths
  localparam int unsigned RowWidth     = $clog2(WordsPerBank);
  localparam int unsigned BankIdxWidth = $clog2(NumBanks);
  localparam int unsigned PortIdxWidth = $clog2(NumNarrowPorts);

  // Wide accesses in flight, also the depth of each part response FIFO
  localparam int unsigned MaxWideOutstanding = 2;
  localparam int unsigned WideCntWidth       = $clog2(MaxWideOutstanding + 1);
  localparam int unsigned RespPtrWidth       = $clog2(MaxWideOutstanding);

endpackage

//--- design/mem_island_types_pkg.sv
/*
 * Memory island types: addresses, data and strobe words of both widths,
 * and the row, bank and port indices derived from the configuration.
 */
package mem_island_types_pkg;

  import mem_island_cfg_pkg::*;

  typedef logic [AddrWidth-1:0] addr_t;

  // Narrow side, also the width of one bank
  typedef logic [NarrowWidth-1:0]     narrow_data_t;
  typedef logic [NarrowStrbWidth-1:0] narrow_strb_t;

  // Wide side
  typedef logic [WideWidth-1:0]     wide_data_t;
  typedef logic [WideStrbWidth-1:0] wide_strb_t;

  // Indices
  typedef logic [RowWidth-1:0]     row_t;
  typedef logic [BankIdxWidth-1:0] bank_idx_t;
  typedef logic [PortIdxWidth-1:0] port_idx_t;

endpackage

//--- design/bank_port_if.sv
/*
 * Request and response channel towards one SRAM bank.
 * Read data follows a grant by one cycle.
 */
`timescale 1ns/1ns

interface bank_port_if;

  import mem_island_types_pkg::*;

  logic         req;
  logic         gnt;
  logic         we;
  row_t         row;
  narrow_data_t wdata;
  narrow_strb_t strb;
  narrow_data_t rdata;

  modport requester (
    output req, we, row, wdata, strb,
    input  gnt, rdata
  );

  modport bank (
    input  req, we, row, wdata, strb,
    output gnt, rdata
  );

endinterface

//--- design/narrow_xbar.sv
/*
 * Narrow crossbar. Routes each narrow port to its bank with round-robin
 * arbitration per bank and returns read data one cycle after the grant.
 */
`timescale 1ns/1ns

module narrow_xbar (
  input  logic                                                             clk_i,
  input  logic                                                             rst_ni,
  input  logic [mem_island_cfg_pkg::NumNarrowPorts-1:0]                    req_i,
  input  logic [mem_island_cfg_pkg::NumNarrowPorts-1:0]                    we_i,
  input  mem_island_types_pkg::addr_t [mem_island_cfg_pkg::NumNarrowPorts-1:0] addr_i,
  input  mem_island_types_pkg::narrow_data_t [mem_island_cfg_pkg::NumNarrowPorts-1:0] wdata_i,
  input  mem_island_types_pkg::narrow_strb_t [mem_island_cfg_pkg::NumNarrowPorts-1:0] strb_i,
  output logic [mem_island_cfg_pkg::NumNarrowPorts-1:0]                    gnt_o,
  output logic [mem_island_cfg_pkg::NumNarrowPorts-1:0]                    rvalid_o,
  output mem_island_types_pkg::narrow_data_t [mem_island_cfg_pkg::NumNarrowPorts-1:0] rdata_o,
  bank_port_if.requester                                                   bank [mem_island_cfg_pkg::NumBanks]
);

  import mem_island_cfg_pkg::*;
  import mem_island_types_pkg::*;

  bank_idx_t [NumNarrowPorts-1:0]          port_bank;
  logic      [NumBanks-1:0][NumNarrowPorts-1:0] bank_req;
  port_idx_t [NumBanks-1:0]                winner;
  port_idx_t [NumBanks-1:0]                rr_q;
  logic      [NumBanks-1:0]                bank_gnt;
  narrow_data_t [NumBanks-1:0]             bank_rdata;
  bank_idx_t [NumNarrowPorts-1:0]          resp_bank_q;
  logic      [NumNarrowPorts-1:0]          resp_valid_q;

  // Bank select from the narrow and wide bank bits
  always_comb begin
    for (int p = 0; p < NumNarrowPorts; p++) begin
      port_bank[p] = addr_i[p][WideBankBit:NarrowBankBit];
    end
  end

  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      for (int p = 0; p < NumNarrowPorts; p++) begin
        bank_req[b][p] = req_i[p] && (port_bank[p] == bank_idx_t'(b));
      end
    end
  end

  // Round-robin pick, the port closest to the pointer wins
  always_comb begin
    int unsigned idx;
    winner = rr_q;
    for (int b = 0; b < NumBanks; b++) begin
      for (int k = NumNarrowPorts - 1; k >= 0; k--) begin
        idx = (rr_q[b] + k) % NumNarrowPorts;
        if (bank_req[b][idx]) begin
          winner[b] = port_idx_t'(idx);
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < NumNarrowPorts; p++) begin
      gnt_o[p] = req_i[p] && bank_gnt[port_bank[p]] &&
                 (winner[port_bank[p]] == port_idx_t'(p));
    end
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    assign bank[b].req   = |bank_req[b];
    assign bank[b].we    = we_i[winner[b]];
    assign bank[b].row   = addr_i[winner[b]][RowLsb +: RowWidth];
    assign bank[b].wdata = wdata_i[winner[b]];
    assign bank[b].strb  = strb_i[winner[b]];
    assign bank_gnt[b]   = bank[b].gnt;
    assign bank_rdata[b] = bank[b].rdata;
  end

  // Pointer moves past the port that was just served
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      for (int b = 0; b < NumBanks; b++) begin
        if (|bank_req[b] && bank_gnt[b]) begin
          rr_q[b] <= (winner[b] == port_idx_t'(NumNarrowPorts - 1)) ? '0 : winner[b] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= '0;
      resp_bank_q  <= '0;
    end else begin
      resp_valid_q <= gnt_o;
      for (int p = 0; p < NumNarrowPorts; p++) begin
        if (gnt_o[p]) begin
          resp_bank_q[p] <= port_bank[p];
        end
      end
    end
  end

  assign rvalid_o = resp_valid_q;

  always_comb begin
    for (int p = 0; p < NumNarrowPorts; p++) begin
      rdata_o[p] = bank_rdata[resp_bank_q[p]];
    end
  end

endmodule

//--- design/wide_splitter.sv
/*
 * Wide port splitter. Issues the halves of a wide access to the two
 * narrow banks of one wide bank and returns the collected data in order.
 */
`timescale 1ns/1ns

module wide_splitter (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  req_i,
  input  logic                                  we_i,
  input  mem_island_types_pkg::addr_t           addr_i,
  input  mem_island_types_pkg::wide_data_t      wdata_i,
  input  mem_island_types_pkg::wide_strb_t      strb_i,
  output logic                                  gnt_o,
  output logic                                  rvalid_o,
  output mem_island_types_pkg::wide_data_t      rdata_o,
  output logic                                  wide_bank_o,
  bank_port_if.requester                        part [mem_island_cfg_pkg::PartsPerWide],
  input  logic [mem_island_cfg_pkg::PartsPerWide-1:0] part_rvalid_i
);

  import mem_island_cfg_pkg::*;
  import mem_island_types_pkg::*;

  logic [WideCntWidth-1:0]      cnt_q;
  logic [PartsPerWide-1:0]      sent_q;
  logic [PartsPerWide-1:0]      part_req;
  logic [PartsPerWide-1:0]      part_gnt;
  logic [PartsPerWide-1:0]      part_take;
  logic [PartsPerWide-1:0]      fifo_valid;
  narrow_data_t [PartsPerWide-1:0] fifo_head;
  logic                         wide_bank_q;
  logic                         req_bank;
  logic                         busy;
  logic                         issue_ok;

  assign req_bank = addr_i[WideBankBit];

  // Busy while any access is partly issued or awaits its response
  assign busy        = (cnt_q != '0) || (|sent_q);
  assign wide_bank_o = busy ? wide_bank_q : req_bank;

  // In-flight accesses all target one wide bank
  assign issue_ok = req_i && (cnt_q < WideCntWidth'(MaxWideOutstanding)) &&
                    (!busy || (req_bank == wide_bank_q));

  assign part_req  = {PartsPerWide{issue_ok}} & ~sent_q;
  assign part_take = part_req & part_gnt;
  assign gnt_o     = issue_ok && (&(sent_q | part_take));
  assign rvalid_o  = &fifo_valid;
  assign rdata_o   = fifo_head;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sent_q      <= '0;
      cnt_q       <= '0;
      wide_bank_q <= 1'b0;
    end else begin
      if (gnt_o) begin
        sent_q <= '0;
      end else begin
        sent_q <= sent_q | part_take;
      end
      if (|part_take) begin
        wide_bank_q <= wide_bank_o;
      end
      if (gnt_o && !rvalid_o) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!gnt_o && rvalid_o) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  for (genvar j = 0; j < PartsPerWide; j++) begin : gen_part
    narrow_data_t            fifo_q [MaxWideOutstanding];
    logic [RespPtrWidth-1:0] wr_ptr_q;
    logic [RespPtrWidth-1:0] rd_ptr_q;
    logic [WideCntWidth-1:0] fill_q;

    assign part[j].req   = part_req[j];
    assign part[j].we    = we_i;
    assign part[j].row   = addr_i[RowLsb +: RowWidth];
    assign part[j].wdata = wdata_i[j*NarrowWidth +: NarrowWidth];
    assign part[j].strb  = strb_i[j*NarrowStrbWidth +: NarrowStrbWidth];
    assign part_gnt[j]   = part[j].gnt;

    // Response storage, one entry per outstanding access
    always_ff @(posedge clk_i) begin
      if (part_rvalid_i[j]) begin
        fifo_q[wr_ptr_q] <= part[j].rdata;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        fill_q   <= '0;
      end else begin
        if (part_rvalid_i[j]) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (rvalid_o) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        if (part_rvalid_i[j] && !rvalid_o) begin
          fill_q <= fill_q + 1'b1;
        end else if (!part_rvalid_i[j] && rvalid_o) begin
          fill_q <= fill_q - 1'b1;
        end
      end
    end

    assign fifo_valid[j] = (fill_q != '0);
    assign fifo_head[j]  = fifo_q[rd_ptr_q];
  end

endmodule

//--- design/bank_unit.sv
/*
 * One SRAM bank with narrow-over-wide arbitration,
 * byte-strobe writes and a one-cycle registered read.
 */
`timescale 1ns/1ns

module bank_unit (
  input  logic       clk_i,
  input  logic       rst_ni,
  bank_port_if.bank  narrow,
  bank_port_if.bank  wide,
  output logic       wide_rvalid_o
);

  import mem_island_cfg_pkg::*;
  import mem_island_types_pkg::*;

  narrow_data_t mem_q [WordsPerBank];
  narrow_data_t rdata_q;
  logic         bank_req;
  logic         bank_we;
  row_t         bank_row;
  narrow_data_t bank_wdata;
  narrow_strb_t bank_strb;
  logic         wide_rvalid_q;

  // Narrow always wins, wide only gets an idle cycle
  assign narrow.gnt = 1'b1;
  assign wide.gnt   = ~narrow.req;

  assign bank_req   = narrow.req | wide.req;
  assign bank_we    = narrow.req ? narrow.we    : wide.we;
  assign bank_row   = narrow.req ? narrow.row   : wide.row;
  assign bank_wdata = narrow.req ? narrow.wdata : wide.wdata;
  assign bank_strb  = narrow.req ? narrow.strb  : wide.strb;

  always_ff @(posedge clk_i) begin
    if (bank_req) begin
      if (bank_we) begin
        for (int i = 0; i < NarrowStrbWidth; i++) begin
          if (bank_strb[i]) begin
            mem_q[bank_row][8*i +: 8] <= bank_wdata[8*i +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[bank_row];
      end
    end
  end

  // Both requesters see the same read port
  assign narrow.rdata = rdata_q;
  assign wide.rdata   = rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wide_rvalid_q <= 1'b0;
    end else begin
      wide_rvalid_q <= wide.req & wide.gnt;
    end
  end

  assign wide_rvalid_o = wide_rvalid_q;

endmodule

//--- design/memory_island_top.sv
/*
 * Memory island top level. Two narrow ports and one wide port share four
 * narrow banks; the wide port reaches the two banks of one wide bank.
 */
`timescale 1ns/1ns

module memory_island_top (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic [mem_island_cfg_pkg::NumNarrowPorts-1:0]          narrow_req_i,
  input  logic [mem_island_cfg_pkg::NumNarrowPorts-1:0]          narrow_we_i,
  input  mem_island_types_pkg::addr_t [mem_island_cfg_pkg::NumNarrowPorts-1:0] narrow_addr_i,
  input  mem_island_types_pkg::narrow_data_t [mem_island_cfg_pkg::NumNarrowPorts-1:0] narrow_wdata_i,
  input  mem_island_types_pkg::narrow_strb_t [mem_island_cfg_pkg::NumNarrowPorts-1:0] narrow_strb_i,
  output logic [mem_island_cfg_pkg::NumNarrowPorts-1:0]          narrow_gnt_o,
  output logic [mem_island_cfg_pkg::NumNarrowPorts-1:0]          narrow_rvalid_o,
  output mem_island_types_pkg::narrow_data_t [mem_island_cfg_pkg::NumNarrowPorts-1:0] narrow_rdata_o,
  input  logic                                                   wide_req_i,
  input  logic                                                   wide_we_i,
  input  mem_island_types_pkg::addr_t                            wide_addr_i,
  input  mem_island_types_pkg::wide_data_t                       wide_wdata_i,
  input  mem_island_types_pkg::wide_strb_t                       wide_strb_i,
  output logic                                                   wide_gnt_o,
  output logic                                                   wide_rvalid_o,
  output mem_island_types_pkg::wide_data_t                       wide_rdata_o
);

  import mem_island_cfg_pkg::*;
  import mem_island_types_pkg::*;

  bank_port_if narrow_bank [NumBanks] ();
  bank_port_if wide_bank [NumBanks] ();
  bank_port_if wide_part [PartsPerWide] ();

  logic                        wide_bank_sel;
  logic [NumBanks-1:0]         bank_wide_gnt;
  logic [NumBanks-1:0]         bank_wide_rvalid;
  narrow_data_t [NumBanks-1:0] bank_wide_rdata;
  logic [PartsPerWide-1:0]     part_rvalid;

  narrow_xbar i_narrow_xbar (
    .clk_i,
    .rst_ni,
    .req_i    ( narrow_req_i    ),
    .we_i     ( narrow_we_i     ),
    .addr_i   ( narrow_addr_i   ),
    .wdata_i  ( narrow_wdata_i  ),
    .strb_i   ( narrow_strb_i   ),
    .gnt_o    ( narrow_gnt_o    ),
    .rvalid_o ( narrow_rvalid_o ),
    .rdata_o  ( narrow_rdata_o  ),
    .bank     ( narrow_bank     )
  );

  wide_splitter i_wide_splitter (
    .clk_i,
    .rst_ni,
    .req_i         ( wide_req_i    ),
    .we_i          ( wide_we_i     ),
    .addr_i        ( wide_addr_i   ),
    .wdata_i       ( wide_wdata_i  ),
    .strb_i        ( wide_strb_i   ),
    .gnt_o         ( wide_gnt_o    ),
    .rvalid_o      ( wide_rvalid_o ),
    .rdata_o       ( wide_rdata_o  ),
    .wide_bank_o   ( wide_bank_sel ),
    .part          ( wide_part     ),
    .part_rvalid_i ( part_rvalid   )
  );

  // Wide parts reach only the selected wide bank, the other one sees no request
  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    assign wide_bank[b].req   = wide_part[b % PartsPerWide].req &
                                (wide_bank_sel == (b / PartsPerWide));
    assign wide_bank[b].we    = wide_part[b % PartsPerWide].we;
    assign wide_bank[b].row   = wide_part[b % PartsPerWide].row;
    assign wide_bank[b].wdata = wide_part[b % PartsPerWide].wdata;
    assign wide_bank[b].strb  = wide_part[b % PartsPerWide].strb;
    assign bank_wide_gnt[b]   = wide_bank[b].gnt;
    assign bank_wide_rdata[b] = wide_bank[b].rdata;

    bank_unit i_bank (
      .clk_i,
      .rst_ni,
      .narrow        ( narrow_bank[b]      ),
      .wide          ( wide_bank[b]        ),
      .wide_rvalid_o ( bank_wide_rvalid[b] )
    );
  end

  // Grants, data and response flags come back from the selected wide bank
  for (genvar j = 0; j < PartsPerWide; j++) begin : gen_part
    assign wide_part[j].gnt   = bank_wide_gnt[wide_bank_sel * PartsPerWide + j];
    assign wide_part[j].rdata = bank_wide_rdata[wide_bank_sel * PartsPerWide + j];
    assign part_rvalid[j]     = bank_wide_rvalid[wide_bank_sel * PartsPerWide + j];
  end

endmodule

//--- tests/tb_memory_island.sv
/*
 * Directed testbench for the memory island. A byte-wide reference memory
 * predicts every read, and responses are checked cycle by cycle.
 */
`timescale 1ns/1ns

module tb_memory_island;

  import mem_island_cfg_pkg::*;
  import mem_island_types_pkg::*;

  // About twenty times the length of all tests together
  localparam int MaxCycles = 2000;

  logic clk;
  logic rst_n;
  logic [NumNarrowPorts-1:0]         narrow_req;
  logic [NumNarrowPorts-1:0]         narrow_we;
  addr_t [NumNarrowPorts-1:0]        narrow_addr;
  narrow_data_t [NumNarrowPorts-1:0] narrow_wdata;
  narrow_strb_t [NumNarrowPorts-1:0] narrow_strb;
  logic [NumNarrowPorts-1:0]         narrow_gnt;
  logic [NumNarrowPorts-1:0]         narrow_rvalid;
  narrow_data_t [NumNarrowPorts-1:0] narrow_rdata;
  logic       wide_req;
  logic       wide_we;
  addr_t      wide_addr;
  wide_data_t wide_wdata;
  wide_strb_t wide_strb;
  logic       wide_gnt;
  logic       wide_rvalid;
  wide_data_t wide_rdata;

  // Reference memory indexed by byte address bits 9 to 0
  logic [7:0] ref_mem [1024];
  logic [31:0] rng_state = 32'h798b;
  int cycle_count = 0;

  // Grants seen in the last cycle and the responses they predict
  logic [NumNarrowPorts-1:0]         narrow_took;
  logic [NumNarrowPorts-1:0]         narrow_was_read;
  narrow_data_t [NumNarrowPorts-1:0] narrow_exp;
  logic       wide_took;
  wide_data_t wide_exp_q [$];
  bit         wide_read_q [$];

  memory_island_top DUT (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .narrow_req_i    ( narrow_req    ),
    .narrow_we_i     ( narrow_we     ),
    .narrow_addr_i   ( narrow_addr   ),
    .narrow_wdata_i  ( narrow_wdata  ),
    .narrow_strb_i   ( narrow_strb   ),
    .narrow_gnt_o    ( narrow_gnt    ),
    .narrow_rvalid_o ( narrow_rvalid ),
    .narrow_rdata_o  ( narrow_rdata  ),
    .wide_req_i      ( wide_req      ),
    .wide_we_i       ( wide_we       ),
    .wide_addr_i     ( wide_addr     ),
    .wide_wdata_i    ( wide_wdata    ),
    .wide_strb_i     ( wide_strb     ),
    .wide_gnt_o      ( wide_gnt      ),
    .wide_rvalid_o   ( wide_rvalid   ),
    .wide_rdata_o    ( wide_rdata    )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MaxCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", MaxCycles);
      report_failure();
    end
  end

  task automatic report_failure();
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic check_narrow(input narrow_data_t got, input narrow_data_t exp,
                              input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic check_wide(input wide_data_t got, input wide_data_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s, got %b expected %b", $time, what, got, exp);
      report_failure();
    end
  endtask

  // Byte merge into the reference model
  function automatic void merge_narrow_write(addr_t a, narrow_data_t d, narrow_strb_t s);
    int base;
    base = a[9:2] * 4;
    for (int i = 0; i < NarrowStrbWidth; i++) begin
      if (s[i]) ref_mem[base + i] = d[8*i +: 8];
    end
  endfunction

  function automatic narrow_data_t expected_narrow_word(addr_t a);
    narrow_data_t d;
    int base;
    base = a[9:2] * 4;
    for (int i = 0; i < NarrowStrbWidth; i++) d[8*i +: 8] = ref_mem[base + i];
    return d;
  endfunction

  // A wide word covers eight bytes with its low half at narrow-bank bit 0
  function automatic void merge_wide_write(addr_t a, wide_data_t d, wide_strb_t s);
    int base;
    base = a[9:3] * 8;
    for (int i = 0; i < WideStrbWidth; i++) begin
      if (s[i]) ref_mem[base + i] = d[8*i +: 8];
    end
  endfunction

  function automatic wide_data_t expected_wide_word(addr_t a);
    wide_data_t d;
    int base;
    base = a[9:3] * 8;
    for (int i = 0; i < WideStrbWidth; i++) d[8*i +: 8] = ref_mem[base + i];
    return d;
  endfunction

  task automatic clear_inputs();
    narrow_req   = '0;
    narrow_we    = '0;
    narrow_addr  = '0;
    narrow_wdata = '0;
    narrow_strb  = '0;
    wide_req     = 1'b0;
    wide_we      = 1'b0;
    wide_addr    = '0;
    wide_wdata   = '0;
    wide_strb    = '0;
  endtask

  // Inputs were driven at a falling edge; record grants, then check responses
  task automatic step_cycle();
    wide_data_t exp_w;
    bit         is_read;
    #1;
    for (int p = 0; p < NumNarrowPorts; p++) begin
      narrow_took[p]     = narrow_req[p] && narrow_gnt[p];
      narrow_was_read[p] = !narrow_we[p];
      if (narrow_took[p] && narrow_we[p]) begin
        merge_narrow_write(narrow_addr[p], narrow_wdata[p], narrow_strb[p]);
      end else if (narrow_took[p]) begin
        narrow_exp[p] = expected_narrow_word(narrow_addr[p]);
      end
    end
    wide_took = wide_req && wide_gnt;
    if (wide_took) begin
      wide_exp_q.push_back(expected_wide_word(wide_addr));
      wide_read_q.push_back(!wide_we);
      if (wide_we) merge_wide_write(wide_addr, wide_wdata, wide_strb);
    end
    @(negedge clk);
    for (int p = 0; p < NumNarrowPorts; p++) begin
      check_flag(narrow_rvalid[p], narrow_took[p], $sformatf("narrow rvalid on port %0d", p));
      if (narrow_took[p] && narrow_was_read[p]) begin
        check_narrow(narrow_rdata[p], narrow_exp[p], $sformatf("narrow read on port %0d", p));
      end
    end
    if (wide_rvalid && wide_exp_q.size() == 0) begin
      $display("Error: a wide response arrived with no wide access outstanding");
      report_failure();
    end else if (wide_rvalid) begin
      exp_w   = wide_exp_q.pop_front();
      is_read = wide_read_q.pop_front();
      if (is_read) check_wide(wide_rdata, exp_w, "wide read data");
    end
  endtask

  task automatic narrow_access(input int p, input logic we, input addr_t a,
                               input narrow_data_t d, input narrow_strb_t s);
    narrow_req[p]   = 1'b1;
    narrow_we[p]    = we;
    narrow_addr[p]  = a;
    narrow_wdata[p] = d;
    narrow_strb[p]  = s;
    step_cycle();
    while (!narrow_took[p]) step_cycle();
    narrow_req[p] = 1'b0;
  endtask

  task automatic wide_access(input logic we, input addr_t a, input wide_data_t d,
                             input wide_strb_t s);
    wide_req   = 1'b1;
    wide_we    = we;
    wide_addr  = a;
    wide_wdata = d;
    wide_strb  = s;
    step_cycle();
    while (!wide_took) step_cycle();
    wide_req = 1'b0;
  endtask

  task automatic drain_responses();
    clear_inputs();
    step_cycle();
    while (wide_exp_q.size() != 0) step_cycle();
  endtask

  // Rows 0 to 7 of every bank get known data
  task automatic fill_memory();
    for (int a = 0; a < 128; a += 4) begin
      narrow_access((a >> 2) % 2, 1'b1, addr_t'(a), next_random(), 4'hf);
    end
    drain_responses();
  endtask

  task automatic narrow_write_readback();
    logic [31:0]  r;
    narrow_strb_t s;
    for (int row = 1; row <= 4; row++) begin
      r = next_random();
      s = r[3:0];
      if (s == 4'hf || s == 4'h0) s = 4'h5;
      narrow_access(1, 1'b1, addr_t'(row * 16 + (row % 4) * 4), next_random(), s);
    end
    for (int row = 1; row <= 4; row++) begin
      narrow_access(0, 1'b0, addr_t'(row * 16 + (row % 4) * 4), '0, '0);
    end
    drain_responses();
  endtask

  task automatic round_robin_one_bank();
    logic [NumNarrowPorts-1:0] prev;
    narrow_req     = 2'b11;
    narrow_addr[0] = 16'h0020;
    narrow_addr[1] = 16'h0030;
    prev = '0;
    for (int c = 0; c < 8; c++) begin
      step_cycle();
      check_flag(^narrow_took, 1'b1, "one grant per cycle on a shared bank");
      if (c > 0) check_flag(narrow_took[1], prev[0], "grant alternates between ports");
      prev = narrow_took;
    end
    drain_responses();
  endtask

  task automatic parallel_banks();
    narrow_req     = 2'b11;
    narrow_addr[0] = 16'h0014;
    narrow_addr[1] = 16'h0028;
    step_cycle();
    check_flag(narrow_took[0], 1'b1, "port 0 granted on its own bank");
    check_flag(narrow_took[1], 1'b1, "port 1 granted on its own bank");
    drain_responses();
  endtask

  task automatic wide_write_narrow_read();
    logic [31:0] r;
    wide_data_t  d;
    r = next_random();
    d = {next_random(), next_random()};
    wide_access(1'b1, 16'h0048, d, r[7:0]);
    narrow_access(0, 1'b0, 16'h0048, '0, '0);
    narrow_access(1, 1'b0, 16'h004c, '0, '0);
    drain_responses();
  endtask

  task automatic narrow_over_wide();
    wide_req       = 1'b1;
    wide_addr      = 16'h0060;
    narrow_req[0]  = 1'b1;
    narrow_addr[0] = 16'h0060;
    for (int c = 0; c < 6; c++) begin
      step_cycle();
      check_flag(narrow_took[0], 1'b1, "narrow port keeps its bank");
      check_flag(wide_took, 1'b0, "wide grant held off by narrow traffic");
    end
    narrow_req[0] = 1'b0;
    step_cycle();
    check_flag(wide_took, 1'b1, "wide grant once narrow traffic stops");
    drain_responses();
  endtask

  task automatic wide_back_to_back();
    addr_t addrs [6];
    addrs = '{16'h0000, 16'h0010, 16'h0020, 16'h0008, 16'h0018, 16'h0030};
    for (int i = 0; i < 6; i++) wide_access(1'b0, addrs[i], '0, '0);
    drain_responses();
  endtask

  initial begin
    rst_n = 1'b0;
    clear_inputs();
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    step_cycle();
    fill_memory();
    narrow_write_readback();
    round_robin_one_bank();
    parallel_banks();
    wide_write_narrow_read();
    narrow_over_wide();
    wide_back_to_back();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- sim.f
design/mem_island_cfg_pkg.sv
design/mem_island_types_pkg.sv
design/bank_port_if.sv
design/narrow_xbar.sv
design/wide_splitter.sv
design/bank_unit.sv
design/memory_island_top.sv
tests/tb_memory_island.sv
